// ==== source/link_pkg.sv ====
package link_pkg;

    // One bus sample as the transmitter drives it.
    typedef struct packed {
        logic scl;
        logic sda_out;    // Level put on sda when enabled.
        logic sda_oe;     // Low leaves sda to the pull-up.
    } line_t;

    // Transmitter frame sequence.
    typedef enum logic [2:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop,
        tx_release
    } tx_state_e;

    // Receiver frame tracking.
    typedef enum logic [1:0] {
        rx_idle,
        rx_data,
        rx_wait_stop
    } rx_state_e;

endpackage

// ==== source/word_pkg.sv ====
package word_pkg;

    localparam int WORD_W = 4;    // Default payload width.

    // Parallel word with its single-cycle strobe.
    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] data;
    } word_strobe_t;

    // One received frame.
    typedef struct packed {
        logic              valid;
        logic              framing_error;
        logic [WORD_W-1:0] data;
    } rx_result_t;

endpackage

// ==== source/nibble_serializer.sv ====
`timescale 1ns/1ps

module nibble_serializer #(
    parameter int DATA_WIDTH = 4
) (
    input  logic                   ack,
    input  logic                   rst,
    input  word_pkg::word_strobe_t word_in,
    output link_pkg::line_t        line,
    output logic                   busy
);
    import link_pkg::*;

    localparam int CNT_W = $clog2(DATA_WIDTH + 1);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(DATA_WIDTH - 1);

    tx_state_e             state;
    logic [1:0]            phase;    // Phases 0 and 1 hold scl low.
    logic [CNT_W-1:0]      bit_cnt;
    logic [DATA_WIDTH-1:0] shreg;
    logic                  sda_out;
    logic                  sda_oe;
    logic                  scl_level;
    logic                  accept;

    // A strobe only counts while no frame is in flight.
    assign accept = word_in.valid && (state == tx_idle);
    assign busy   = (state != tx_idle);

    // Bus clock stays high when no frame is running.
    assign scl_level = ((state == tx_idle) || (state == tx_release)) ? 1'b1 : phase[1];

    assign line = '{scl: scl_level, sda_out: sda_out, sda_oe: sda_oe};

    // Parked on the scl-high phase while idle.
    always_ff @(posedge ack or negedge rst)
    begin
        if (!rst)
            phase <= 2'd2;
        else if (state == tx_idle)
            phase <= 2'd2;
        else
            phase <= phase + 2'd1;
    end

    always_ff @(posedge ack or negedge rst)
    begin
        if (!rst)
        begin
            state   <= tx_idle;
            bit_cnt <= '0;
            sda_out <= 1'b1;
            sda_oe  <= 1'b0;
        end
        else
        begin
            case (state)
                tx_idle:
                begin
                    if (accept)
                        state <= tx_start;
                end
                tx_start:
                begin
                    // Pull sda low in the middle of scl high.
                    if (phase == 2'd2)
                    begin
                        sda_oe  <= 1'b1;
                        sda_out <= 1'b0;
                    end
                    else if (phase == 2'd3)
                    begin
                        state   <= tx_data;
                        bit_cnt <= '0;
                    end
                end
                tx_data:
                begin
                    if (phase == 2'd0)
                        sda_out <= shreg[DATA_WIDTH-1];    // MSB first.
                    else if (phase == 2'd3)
                    begin
                        if (bit_cnt == LAST_BIT)
                            state <= tx_stop;
                        else
                            bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                tx_stop:
                begin
                    if (phase == 2'd0)
                        sda_out <= 1'b0;    // Low through scl low.
                    else if (phase == 2'd2)
                        sda_out <= 1'b1;    // Rises mid scl high.
                    else if (phase == 2'd3)
                        state <= tx_release;
                end
                tx_release:
                begin
                    if (phase == 2'd0)
                        sda_oe <= 1'b0;
                    else if (phase == 2'd3)
                        state <= tx_idle;
                end
                default:
                    state <= tx_idle;
            endcase
        end
    end

    // Word shifts out towards the MSB.
    always_ff @(posedge ack)
    begin
        if (accept)
            shreg <= word_in.data[DATA_WIDTH-1:0];
        else if ((state == tx_data) && (phase == 2'd0))
            shreg <= shreg << 1;
    end

endmodule

// ==== source/frame_deserializer.sv ====
`timescale 1ns/1ps

module frame_deserializer #(
    parameter int DATA_WIDTH = 4
) (
    input  logic                         ack,
    input  logic                         rst,
    input  logic                         scl,
    input  logic                         sda,
    output word_pkg::rx_result_t         rx_out,
    output logic [2**DATA_WIDTH-1:0]     onehot
);
    import link_pkg::*;

    localparam int CNT_W    = $clog2(DATA_WIDTH + 1);
    localparam int ONEHOT_W = 2**DATA_WIDTH;
    localparam int RES_W    = $bits(rx_out.data);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(DATA_WIDTH - 1);

    rx_state_e             state;
    logic                  scl_q;
    logic                  sda_q;
    logic [CNT_W-1:0]      bit_cnt;
    logic [DATA_WIDTH-1:0] shreg;
    logic                  stop_armed;    // Stop clock seen with sda low.
    logic                  start_cond;
    logic                  stop_cond;
    logic                  scl_rise;
    logic                  frame_ok;
    logic                  frame_err;

    // sda moving while scl is high marks frame bounds.
    assign start_cond = scl && scl_q && sda_q && !sda;
    assign stop_cond  = scl && scl_q && !sda_q && sda;
    assign scl_rise   = scl && !scl_q;

    assign frame_ok  = (state == rx_wait_stop) && stop_cond;
    assign frame_err = ((state == rx_data) && (start_cond || stop_cond)) ||
                       ((state == rx_wait_stop) &&
                        (start_cond || (scl_rise && (sda || stop_armed))));

    always_ff @(posedge ack or negedge rst)
    begin
        if (!rst)
        begin
            state      <= rx_idle;
            bit_cnt    <= '0;
            stop_armed <= 1'b0;
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            case (state)
                rx_idle:
                begin
                    if (start_cond)
                    begin
                        state   <= rx_data;
                        bit_cnt <= '0;
                    end
                end
                rx_data:
                begin
                    if (start_cond)
                        bit_cnt <= '0;    // Repeated start, begin again.
                    else if (stop_cond)
                        state <= rx_idle;
                    else if (scl_rise)
                    begin
                        if (bit_cnt == LAST_BIT)
                        begin
                            state      <= rx_wait_stop;
                            stop_armed <= 1'b0;
                        end
                        else
                            bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                rx_wait_stop:
                begin
                    if (start_cond)
                    begin
                        state   <= rx_data;
                        bit_cnt <= '0;
                    end
                    else if (frame_ok || frame_err)
                        state <= rx_idle;
                    else if (scl_rise)
                        stop_armed <= 1'b1;
                end
                default:
                    state <= rx_idle;
            endcase
        end
    end

    // Bits arrive MSB first on scl rise.
    always_ff @(posedge ack)
    begin
        if ((state == rx_data) && scl_rise)
            shreg <= (shreg << 1) | DATA_WIDTH'(sda);
    end

    always_ff @(posedge ack or negedge rst)
    begin
        if (!rst)
        begin
            rx_out <= '0;
            onehot <= '0;
        end
        else
        begin
            rx_out.valid         <= frame_ok || frame_err;
            rx_out.framing_error <= frame_err;
            if (frame_ok)
            begin
                rx_out.data <= RES_W'(shreg);
                onehot      <= ONEHOT_W'(1) << shreg;
            end
            else if (frame_err)
                onehot <= '0;    // Bad frame clears the bank.
        end
    end

endmodule

// ==== source/serial_link_top.sv ====
`timescale 1ns/1ps

module serial_link_top #(
    parameter int DATA_WIDTH = 4
) (
    input  logic                     ack,
    input  logic                     rst,
    input  word_pkg::word_strobe_t   word_in,
    output logic                     busy,
    output logic                     scl,
    output logic                     sda,
    output word_pkg::rx_result_t     rx_out,
    output logic [2**DATA_WIDTH-1:0] onehot
);
    import link_pkg::*;

    line_t tx_line;

    nibble_serializer #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_tx (
        .ack     (ack),
        .rst     (rst),
        .word_in (word_in),
        .line    (tx_line),
        .busy    (busy)
    );

    assign scl = tx_line.scl;

    // Open-drain sda, pulled up when nobody drives it.
    assign sda = tx_line.sda_oe ? tx_line.sda_out : 1'b1;

    // Receiver only sees the resolved pins.
    frame_deserializer #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_rx (
        .ack    (ack),
        .rst    (rst),
        .scl    (scl),
        .sda    (sda),
        .rx_out (rx_out),
        .onehot (onehot)
    );

endmodule

// ==== test/serial_link_tb.sv ====
`timescale 1ns/1ps

module serial_link_tb;
    localparam int DATA_WIDTH     = 4;
    localparam int ONEHOT_W       = 2**DATA_WIDTH;
    localparam int N_STROBES      = 40;
    localparam int MAX_GAP        = 32;
    localparam int FRAME_CYCLES   = 4 * (DATA_WIDTH + 3) + 4;
    localparam int TIMEOUT_CYCLES = N_STROBES * (FRAME_CYCLES + MAX_GAP) + 200;

    logic                   ack;
    logic                   rst;
    word_pkg::word_strobe_t word_in;
    logic                   busy;
    logic                   scl;
    logic                   sda;
    word_pkg::rx_result_t   rx_out;
    logic [ONEHOT_W-1:0]    onehot;

    logic [31:0]           lfsr_state;
    logic [DATA_WIDTH-1:0] exp_q[$];    // Words the DUT accepted.
    logic [ONEHOT_W-1:0]   exp_onehot;
    logic                  prev_scl;
    logic                  prev_sda;
    logic                  mon_active;
    int                    mon_cnt;     // Data bits plus the stop clock.
    logic [DATA_WIDTH-1:0] mon_word;
    int                    busy_run;
    int                    errors;
    int                    accepted_count;
    int                    dropped_count;
    int                    rx_count;
    int                    cycle_count;

    serial_link_top #(
        .DATA_WIDTH (DATA_WIDTH)
    ) uut (
        .ack     (ack),
        .rst     (rst),
        .word_in (word_in),
        .busy    (busy),
        .scl     (scl),
        .sda     (sda),
        .rx_out  (rx_out),
        .onehot  (onehot)
    );

    initial
    begin
        ack = 1'b0;
        forever #20 ack = ~ack;
    end

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic record_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic check_idle_pins();
        assert (scl === 1'b1)
        else record_error($sformatf("[FAIL] scl=%h expected 1", scl));
        assert (sda === 1'b1)
        else record_error($sformatf("[FAIL] sda=%h expected 1", sda));
        assert (busy === 1'b0)
        else record_error($sformatf("[FAIL] busy=%h expected 0", busy));
        assert (rx_out.valid === 1'b0)
        else record_error($sformatf("[FAIL] rx_out.valid=%h expected 0", rx_out.valid));
        assert (onehot === '0)
        else record_error($sformatf("[FAIL] onehot=%h expected 0", onehot));
    endtask

    // Busy must rise the cycle after an accepted strobe.
    assert property (@(posedge ack) disable iff (!rst) (word_in.valid && !busy) |=> busy)
    else
        record_error($sformatf("[FAIL] busy=%h expected 1 after accepted strobe",
                               $sampled(busy)));

    // Receiver result is a single-cycle strobe.
    assert property (@(posedge ack) disable iff (!rst) rx_out.valid |=> !rx_out.valid)
    else
        record_error($sformatf("[FAIL] rx_out.valid=%h expected 0 after strobe",
                               $sampled(rx_out.valid)));

    // Outputs are stable at the falling edge.
    always @(negedge ack)
    begin
        if (!rst)
        begin
            prev_scl   = 1'b1;
            prev_sda   = 1'b1;
            mon_active = 1'b0;
            busy_run   = 0;
        end
        else
        begin
            if (word_in.valid && !busy)
            begin
                exp_q.push_back(word_in.data[DATA_WIDTH-1:0]);
                accepted_count++;
            end
            else if (word_in.valid)
                dropped_count++;

            // Pin-level decode of the bus.
            if (prev_scl && scl && (sda !== prev_sda))
            begin
                if (!sda)
                begin
                    assert (!mon_active)
                    else record_error("Start condition inside a frame");
                    mon_active = 1'b1;
                    mon_cnt    = 0;
                    mon_word   = '0;
                end
                else
                begin
                    assert (mon_active && (mon_cnt == DATA_WIDTH + 1))
                    else record_error("Stop condition without all data bits and the stop clock");
                    if (exp_q.size() == 0)
                        record_error("Stop condition with no accepted word pending");
                    else
                    begin
                        assert (mon_word === exp_q[0])
                        else record_error($sformatf("[FAIL] sda word=%h expected %h",
                                                    mon_word, exp_q[0]));
                    end
                    mon_active = 1'b0;
                end
            end
            else if (!prev_scl && scl && mon_active)
            begin
                if (mon_cnt < DATA_WIDTH)
                    mon_word = {mon_word[DATA_WIDTH-2:0], sda};
                else
                begin
                    // Stop clock, sda still held low.
                    assert ((mon_cnt == DATA_WIDTH) && (sda === 1'b0))
                    else record_error("Extra scl pulse or sda high before the stop condition");
                end
                mon_cnt++;
            end
            prev_scl = scl;
            prev_sda = sda;

            if (rx_out.valid)
            begin
                rx_count++;
                assert (rx_out.framing_error === 1'b0)
                else record_error($sformatf("[FAIL] rx_out.framing_error=%h expected 0",
                                            rx_out.framing_error));
                if (exp_q.size() == 0)
                    record_error("Receiver reported a word that was never accepted");
                else
                begin
                    assert (rx_out.data === exp_q[0])
                    else record_error($sformatf("[FAIL] rx_out.data=%h expected %h",
                                                rx_out.data, exp_q[0]));
                    exp_onehot           = '0;
                    exp_onehot[exp_q[0]] = 1'b1;
                    void'(exp_q.pop_front());
                end
            end

            assert (onehot === exp_onehot)
            else record_error($sformatf("[FAIL] onehot=%h expected %h", onehot, exp_onehot));

            busy_run = busy ? busy_run + 1 : 0;
            assert (busy_run <= FRAME_CYCLES)
            else record_error("Busy stayed high longer than one frame");
        end
    end

    always @(posedge ack)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, frames still pending", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    initial
    begin
        logic [31:0] gap;
        logic [31:0] word;

        rst            = 1'b0;
        word_in        = '0;
        lfsr_state     = 32'd89932;
        exp_onehot     = '0;
        errors         = 0;
        accepted_count = 0;
        dropped_count  = 0;
        rx_count       = 0;
        cycle_count    = 0;

        repeat (2) @(negedge ack);
        check_idle_pins();
        repeat (3) @(posedge ack);
        rst <= 1'b1;
        @(negedge ack);
        check_idle_pins();

        // Random gaps land strobes both in and out of frames.
        for (int i = 0; i < N_STROBES; i++)
        begin
            take_bits(5, gap);
            repeat (gap) @(posedge ack);
            take_bits(DATA_WIDTH, word);
            @(posedge ack);
            word_in.data  <= word[DATA_WIDTH-1:0];
            word_in.valid <= 1'b1;
            @(posedge ack);
            word_in.valid <= 1'b0;
        end

        while (busy || (exp_q.size() != 0))
            @(posedge ack);
        repeat (4) @(posedge ack);

        assert (rx_count == accepted_count)
        else record_error($sformatf("[FAIL] rx valid count=%h expected %h",
                                    rx_count, accepted_count));
        assert ((accepted_count > 0) && (dropped_count > 0))
        else record_error("Stimulus did not reach both accepted and dropped strobes");

        $display("Errors: %0d  accepted: %0d  dropped: %0d  received: %0d",
                 errors, accepted_count, dropped_count, rx_count);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== serial_link.f ====
source/link_pkg.sv
source/word_pkg.sv
source/nibble_serializer.sv
source/frame_deserializer.sv
source/serial_link_top.sv
test/serial_link_tb.sv
